/* vlog.f */
hw/fu_pkg.sv
hw/fu_issue_decode.sv
hw/fu_alu.sv
hw/fu_mult.sv
hw/fu_cdb_select.sv
hw/fu_cdb.sv
tb/fu_cdb_tb.sv

/* Makefile */
SRCS := $(wildcard hw/*.sv tb/*.sv)

.PHONY: all run clean

all: obj_dir/Vfu_cdb_tb

obj_dir/Vfu_cdb_tb: vlog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module fu_cdb_tb \
		-f vlog.f -o Vfu_cdb_tb

run: obj_dir/Vfu_cdb_tb
	./obj_dir/Vfu_cdb_tb | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log

/* tb/fu_cdb_tb.sv */
`timescale 1ns/1ps

module fu_cdb_tb;

    localparam int ISSUE_W     = fu_pkg::DEF_ISSUE_W;
    localparam int NUM_ALU     = fu_pkg::DEF_NUM_ALU;
    localparam int N_CDB       = fu_pkg::DEF_N_CDB;
    localparam int MULT_STAGES = fu_pkg::DEF_MULT_STAGES;
    localparam int N_RAND      = 200;
    localparam int N_ISSUE     = 2 * N_RAND + 8;
    localparam int LIMIT       = 4 * N_ISSUE + 200;
    // branch ROB indices start here and result ops stay below
    localparam int BR_ROB_BASE = 24;

    logic                         clock;
    logic                         reset;
    logic                         squash;
    logic [ISSUE_W-1:0]           issue_valid;
    fu_pkg::fu_op_e [ISSUE_W-1:0] issue_op;
    fu_pkg::tag_t [ISSUE_W-1:0]   issue_tag;
    fu_pkg::rob_t [ISSUE_W-1:0]   issue_rob;
    fu_pkg::data_t [ISSUE_W-1:0]  issue_a;
    fu_pkg::data_t [ISSUE_W-1:0]  issue_b;
    logic [NUM_ALU-1:0]           alu_avail;
    logic                         mult_avail;
    logic [N_CDB-1:0]             cdb_valid;
    fu_pkg::tag_t [N_CDB-1:0]     cdb_tag;
    fu_pkg::data_t [N_CDB-1:0]    cdb_data;
    fu_pkg::rob_t [N_CDB-1:0]     cdb_rob;
    logic [NUM_ALU-1:0]           cond_valid;
    logic [NUM_ALU-1:0]           cond_taken;
    fu_pkg::rob_t [NUM_ALU-1:0]   cond_rob;

    fu_cdb #(
        .ISSUE_W(ISSUE_W),
        .NUM_ALU(NUM_ALU),
        .N_CDB(N_CDB),
        .MULT_STAGES(MULT_STAGES)
    ) dut_i (
        .clock(clock),
        .reset(reset),
        .squash(squash),
        .issue_valid(issue_valid),
        .issue_op(issue_op),
        .issue_tag(issue_tag),
        .issue_rob(issue_rob),
        .issue_a(issue_a),
        .issue_b(issue_b),
        .alu_avail(alu_avail),
        .mult_avail(mult_avail),
        .cdb_valid(cdb_valid),
        .cdb_tag(cdb_tag),
        .cdb_data(cdb_data),
        .cdb_rob(cdb_rob),
        .cond_valid(cond_valid),
        .cond_taken(cond_taken),
        .cond_rob(cond_rob)
    );

    // staged issue for the next rising edge
    logic [ISSUE_W-1:0]           nx_valid;
    fu_pkg::fu_op_e [ISSUE_W-1:0] nx_op;
    fu_pkg::tag_t [ISSUE_W-1:0]   nx_tag;
    fu_pkg::rob_t [ISSUE_W-1:0]   nx_rob;
    fu_pkg::data_t [ISSUE_W-1:0]  nx_a;
    fu_pkg::data_t [ISSUE_W-1:0]  nx_b;
    logic                         nx_squash;

    // scoreboard keyed by tag
    logic          sb_live [64];
    fu_pkg::data_t sb_data [64];
    fu_pkg::rob_t  sb_rob  [64];
    logic          sb_mult [64];
    int            sb_due  [64];
    int            live_cnt;
    fu_pkg::tag_t  pool [$];
    fu_pkg::tag_t  mult_order [$];

    // expected branch outcomes by step number mod 4
    int            br_n   [4];
    fu_pkg::rob_t  br_rob [4][ISSUE_W];
    logic          br_tk  [4][ISSUE_W];
    int            br_seq;

    int  seed = 32'haf95;
    int  step_no;
    int  prev_alu;
    logic prev_mult;
    int  cycles;

    task automatic report_mismatch(input string msg);
        $display("** FAIL **");
        $display("mismatch at %0d ns: %s", $time, msg);
        $fatal(1);
    endtask

    function automatic fu_pkg::data_t model_result(fu_pkg::fu_op_e op, fu_pkg::data_t a,
                                                   fu_pkg::data_t b);
        logic signed [63:0] p;
        p = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        case (op)
            fu_pkg::OP_ADD:  return a + b;
            fu_pkg::OP_SUB:  return a - b;
            fu_pkg::OP_AND:  return a & b;
            fu_pkg::OP_OR:   return a | b;
            fu_pkg::OP_XOR:  return a ^ b;
            fu_pkg::OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            fu_pkg::OP_SLL:  return a << b[4:0];
            fu_pkg::OP_SRL:  return a >> b[4:0];
            fu_pkg::OP_MUL:  return p[31:0];
            fu_pkg::OP_MULH: return p[63:32];
            default:         return 32'd0;
        endcase
    endfunction

    function automatic logic model_taken(fu_pkg::fu_op_e op, fu_pkg::data_t a,
                                         fu_pkg::data_t b);
        case (op)
            fu_pkg::OP_BEQ: return a == b;
            fu_pkg::OP_BNE: return a != b;
            fu_pkg::OP_BLT: return $signed(a) < $signed(b);
            default:        return 1'b0;
        endcase
    endfunction

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("** FAIL **");
            $display("timeout: run went past %0d cycles", LIMIT);
            $fatal(1);
        end
    end

    // a cleared machine shows nothing and has every unit free
    assert property (@(posedge clock) $past(reset || squash) |->
                     (cdb_valid == '0 && cond_valid == '0 && (&alu_avail) && mult_avail))
        else report_mismatch("state not cleared after reset or squash");

    // CDB ports fill from port 0 without gaps
    assert property (@(posedge clock) disable iff (reset)
                     ((cdb_valid & (cdb_valid + 1'b1)) == '0))
        else report_mismatch("cdb_valid ports not filled from port 0");

    task automatic clear_next();
        nx_valid  = '0;
        nx_op     = '0;
        nx_tag    = '0;
        nx_rob    = '0;
        nx_a      = '0;
        nx_b      = '0;
        nx_squash = 1'b0;
        br_n[(step_no + 2) % 4] = 0;
        prev_alu  = 0;
        prev_mult = 1'b0;
    endtask

    task automatic add_op(input int i, input fu_pkg::fu_op_e op, input fu_pkg::data_t a,
                          input fu_pkg::data_t b, input logic timed);
        fu_pkg::tag_t t;
        fu_pkg::rob_t r;
        int           bi;
        bi = (step_no + 2) % 4;
        t  = '0;
        if (fu_pkg::is_branch_op(op)) begin
            r = fu_pkg::rob_t'(BR_ROB_BASE + br_seq % 8);
            br_seq++;
            br_rob[bi][br_n[bi]] = r;
            br_tk[bi][br_n[bi]]  = model_taken(op, a, b);
            br_n[bi]++;
        end else begin
            t = pool.pop_front();
            r = fu_pkg::rob_t'(t % BR_ROB_BASE);
            sb_live[t] = 1'b1;
            sb_data[t] = model_result(op, a, b);
            sb_rob[t]  = r;
            sb_mult[t] = fu_pkg::is_mult_op(op);
            sb_due[t]  = timed ? step_no + MULT_STAGES + 2 : -1;
            live_cnt++;
            if (fu_pkg::is_mult_op(op)) begin
                mult_order.push_back(t);
            end
        end
        nx_valid[i] = 1'b1;
        nx_op[i]    = op;
        nx_tag[i]   = t;
        nx_rob[i]   = r;
        nx_a[i]     = a;
        nx_b[i]     = b;
    endtask

    task automatic choose_random();
        int             alu_left;
        logic           mult_ok;
        int             k;
        int             n_alu;
        logic           n_mult;
        fu_pkg::fu_op_e op;
        fu_pkg::data_t  a;
        fu_pkg::data_t  b;
        // ops still in flight toward the DUT lower what is safe to send
        alu_left = $countones(alu_avail) - prev_alu;
        mult_ok  = mult_avail && !prev_mult;
        clear_next();
        n_alu  = 0;
        n_mult = 1'b0;
        for (int i = 0; i < ISSUE_W; i++) begin
            if ({$random(seed)} % 4 == 0 || pool.size() == 0) continue;
            k  = {$random(seed)} % 13;
            op = fu_pkg::fu_op_e'(k);
            if (fu_pkg::is_mult_op(op) && !mult_ok) op = fu_pkg::OP_ADD;
            if (!fu_pkg::is_mult_op(op) && alu_left <= 0) continue;
            a = $random(seed);
            b = ({$random(seed)} % 4 == 0) ? a : $random(seed);
            add_op(i, op, a, b, 1'b0);
            if (fu_pkg::is_mult_op(op)) begin
                mult_ok = 1'b0;
                n_mult  = 1'b1;
            end else begin
                alu_left--;
                n_alu++;
            end
        end
        prev_alu  = n_alu;
        prev_mult = n_mult;
    endtask

    task automatic check_outputs();
        fu_pkg::tag_t t;
        int           idx;
        int           hits;
        logic         found;
        logic         used [ISSUE_W];
        for (int p = 0; p < N_CDB; p++) begin
            if (cdb_valid[p]) begin
                t = cdb_tag[p];
                assert (sb_live[t])
                    else report_mismatch($sformatf("tag %0d broadcast while not pending", t));
                assert (cdb_data[p] == sb_data[t])
                    else report_mismatch($sformatf("tag %0d data %h, expected %h", t,
                                                   cdb_data[p], sb_data[t]));
                assert (cdb_rob[p] == sb_rob[t])
                    else report_mismatch($sformatf("tag %0d rob %0d, expected %0d", t,
                                                   cdb_rob[p], sb_rob[t]));
                if (sb_mult[t]) begin
                    assert (mult_order.size() > 0 && mult_order[0] == t)
                        else report_mismatch($sformatf("multiply tag %0d out of order", t));
                    void'(mult_order.pop_front());
                end
                if (sb_due[t] >= 0) begin
                    assert (step_no == sb_due[t])
                        else report_mismatch($sformatf("multiply latency off by %0d",
                                                       step_no - sb_due[t]));
                end
                sb_live[t] = 1'b0;
                live_cnt--;
                pool.push_back(t);
            end
        end
        idx  = step_no % 4;
        hits = 0;
        for (int k = 0; k < ISSUE_W; k++) used[k] = 1'b0;
        for (int j = 0; j < NUM_ALU; j++) begin
            if (cond_valid[j]) begin
                found = 1'b0;
                for (int k = 0; k < br_n[idx]; k++) begin
                    if (!used[k] && !found && br_rob[idx][k] == cond_rob[j]) begin
                        found   = 1'b1;
                        used[k] = 1'b1;
                        assert (cond_taken[j] == br_tk[idx][k])
                            else report_mismatch($sformatf("rob %0d taken wrong", cond_rob[j]));
                    end
                end
                assert (found)
                    else report_mismatch($sformatf("unexpected cond_valid, rob %0d",
                                                   cond_rob[j]));
                hits++;
            end
        end
        assert (hits == br_n[idx])
            else report_mismatch($sformatf("%0d cond pulses, expected %0d", hits, br_n[idx]));
        br_n[idx] = 0;
    endtask

    task automatic step();
        step_no++;
        @(posedge clock);
        issue_valid <= nx_valid;
        issue_op    <= nx_op;
        issue_tag   <= nx_tag;
        issue_rob   <= nx_rob;
        issue_a     <= nx_a;
        issue_b     <= nx_b;
        squash      <= nx_squash;
        @(negedge clock);
        check_outputs();
    endtask

    task automatic flush_scoreboard();
        pool.delete();
        mult_order.delete();
        for (int t = 0; t < 64; t++) begin
            sb_live[t] = 1'b0;
            pool.push_back(fu_pkg::tag_t'(t));
        end
        for (int i = 0; i < 4; i++) br_n[i] = 0;
        live_cnt = 0;
    endtask

    initial begin
        reset       = 1'b1;
        squash      = 1'b0;
        issue_valid = '0;
        issue_op    = '0;
        issue_tag   = '0;
        issue_rob   = '0;
        issue_a     = '0;
        issue_b     = '0;
        cycles      = 0;
        step_no     = 0;
        br_seq      = 0;
        prev_alu    = 0;
        prev_mult   = 1'b0;
        flush_scoreboard();
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);

        repeat (N_RAND) begin
            choose_random();
            step();
        end
        // squash mid-stream while results may still be queued in the units
        clear_next();
        step();
        clear_next();
        nx_squash = 1'b1;
        step();
        flush_scoreboard();
        clear_next();
        step();

        repeat (N_RAND) begin
            choose_random();
            step();
        end
        clear_next();
        repeat (40) step();
        assert (live_cnt == 0)
            else report_mismatch($sformatf("%0d results never broadcast", live_cnt));

        // timed multiply into an idle machine then back to back ones
        for (int m = 0; m < 4; m++) begin
            clear_next();
            add_op(0, (m % 2) ? fu_pkg::OP_MULH : fu_pkg::OP_MUL, $random(seed),
                   $random(seed), m == 0);
            step();
        end
        clear_next();
        repeat (20) step();
        assert (live_cnt == 0)
            else report_mismatch("multiplies left over after drain");

        $display("** PASS **");
        $finish;
    end

endmodule

/* hw/fu_cdb.sv */
`timescale 1ns/1ps

module fu_cdb #(
    parameter int ISSUE_W     = fu_pkg::DEF_ISSUE_W,
    parameter int NUM_ALU     = fu_pkg::DEF_NUM_ALU,
    parameter int N_CDB       = fu_pkg::DEF_N_CDB,
    parameter int MULT_STAGES = fu_pkg::DEF_MULT_STAGES
) (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         squash,

    input  logic [ISSUE_W-1:0]           issue_valid,
    input  fu_pkg::fu_op_e [ISSUE_W-1:0] issue_op,
    input  fu_pkg::tag_t [ISSUE_W-1:0]   issue_tag,
    input  fu_pkg::rob_t [ISSUE_W-1:0]   issue_rob,
    input  fu_pkg::data_t [ISSUE_W-1:0]  issue_a,
    input  fu_pkg::data_t [ISSUE_W-1:0]  issue_b,

    output logic [NUM_ALU-1:0]           alu_avail,
    output logic                         mult_avail,
    output logic [N_CDB-1:0]             cdb_valid,
    output fu_pkg::tag_t [N_CDB-1:0]     cdb_tag,
    output fu_pkg::data_t [N_CDB-1:0]    cdb_data,
    output fu_pkg::rob_t [N_CDB-1:0]     cdb_rob,
    output logic [NUM_ALU-1:0]           cond_valid,
    output logic [NUM_ALU-1:0]           cond_taken,
    output fu_pkg::rob_t [NUM_ALU-1:0]   cond_rob
);

    // decode to units
    logic [NUM_ALU-1:0]           alu_start;
    fu_pkg::fu_op_e [NUM_ALU-1:0] alu_op;
    fu_pkg::tag_t [NUM_ALU-1:0]   alu_tag;
    fu_pkg::rob_t [NUM_ALU-1:0]   alu_rob;
    fu_pkg::data_t [NUM_ALU-1:0]  alu_a;
    fu_pkg::data_t [NUM_ALU-1:0]  alu_b;
    logic                         mult_start;
    fu_pkg::fu_op_e               mult_op;
    fu_pkg::tag_t                 mult_tag;
    fu_pkg::rob_t                 mult_rob;
    fu_pkg::data_t                mult_a;
    fu_pkg::data_t                mult_b;

    // units to selector
    logic [NUM_ALU-1:0]           alu_done;
    fu_pkg::tag_t [NUM_ALU-1:0]   alu_done_tag;
    fu_pkg::rob_t [NUM_ALU-1:0]   alu_done_rob;
    fu_pkg::data_t [NUM_ALU-1:0]  alu_done_data;
    logic [NUM_ALU-1:0]           alu_grant;
    logic                         mult_done;
    fu_pkg::tag_t                 mult_done_tag;
    fu_pkg::rob_t                 mult_done_rob;
    fu_pkg::data_t                mult_done_data;
    logic                         mult_grant;

    fu_issue_decode #(
        .ISSUE_W(ISSUE_W),
        .NUM_ALU(NUM_ALU)
    ) decode_inst (
        .issue_valid(issue_valid),
        .issue_op(issue_op),
        .issue_tag(issue_tag),
        .issue_rob(issue_rob),
        .issue_a(issue_a),
        .issue_b(issue_b),
        .alu_free(alu_avail),
        .alu_start(alu_start),
        .alu_op(alu_op),
        .alu_tag(alu_tag),
        .alu_rob(alu_rob),
        .alu_a(alu_a),
        .alu_b(alu_b),
        .mult_start(mult_start),
        .mult_op(mult_op),
        .mult_tag(mult_tag),
        .mult_rob(mult_rob),
        .mult_a(mult_a),
        .mult_b(mult_b)
    );

    for (genvar j = 0; j < NUM_ALU; j++) begin : g_alu
        fu_alu alu_inst (
            .clock(clock),
            .reset(reset),
            .squash(squash),
            .start(alu_start[j]),
            .op(alu_op[j]),
            .tag(alu_tag[j]),
            .rob(alu_rob[j]),
            .a(alu_a[j]),
            .b(alu_b[j]),
            .grant(alu_grant[j]),
            .free(alu_avail[j]),
            .done(alu_done[j]),
            .done_tag(alu_done_tag[j]),
            .done_rob(alu_done_rob[j]),
            .done_data(alu_done_data[j]),
            .cond_valid(cond_valid[j]),
            .cond_taken(cond_taken[j]),
            .cond_rob(cond_rob[j])
        );
    end

    fu_mult #(
        .MULT_STAGES(MULT_STAGES)
    ) mult_inst (
        .clock(clock),
        .reset(reset),
        .squash(squash),
        .start(mult_start),
        .op(mult_op),
        .tag(mult_tag),
        .rob(mult_rob),
        .a(mult_a),
        .b(mult_b),
        .grant(mult_grant),
        .ready(mult_avail),
        .done(mult_done),
        .done_tag(mult_done_tag),
        .done_rob(mult_done_rob),
        .done_data(mult_done_data)
    );

    fu_cdb_select #(
        .NUM_ALU(NUM_ALU),
        .N_CDB(N_CDB)
    ) select_inst (
        .clock(clock),
        .reset(reset),
        .squash(squash),
        .alu_done(alu_done),
        .alu_done_tag(alu_done_tag),
        .alu_done_rob(alu_done_rob),
        .alu_done_data(alu_done_data),
        .mult_done(mult_done),
        .mult_done_tag(mult_done_tag),
        .mult_done_rob(mult_done_rob),
        .mult_done_data(mult_done_data),
        .alu_grant(alu_grant),
        .mult_grant(mult_grant),
        .cdb_valid(cdb_valid),
        .cdb_tag(cdb_tag),
        .cdb_data(cdb_data),
        .cdb_rob(cdb_rob)
    );

endmodule

/* hw/fu_cdb_select.sv */
`timescale 1ns/1ps

module fu_cdb_select #(
    parameter int NUM_ALU = fu_pkg::DEF_NUM_ALU,
    parameter int N_CDB   = fu_pkg::DEF_N_CDB
) (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         squash,

    input  logic [NUM_ALU-1:0]           alu_done,
    input  fu_pkg::tag_t [NUM_ALU-1:0]   alu_done_tag,
    input  fu_pkg::rob_t [NUM_ALU-1:0]   alu_done_rob,
    input  fu_pkg::data_t [NUM_ALU-1:0]  alu_done_data,
    input  logic                         mult_done,
    input  fu_pkg::tag_t                 mult_done_tag,
    input  fu_pkg::rob_t                 mult_done_rob,
    input  fu_pkg::data_t                mult_done_data,

    output logic [NUM_ALU-1:0]           alu_grant,
    output logic                         mult_grant,
    output logic [N_CDB-1:0]             cdb_valid,
    output fu_pkg::tag_t [N_CDB-1:0]     cdb_tag,
    output fu_pkg::data_t [N_CDB-1:0]    cdb_data,
    output fu_pkg::rob_t [N_CDB-1:0]     cdb_rob
);

    logic [N_CDB-1:0]          sel_valid;
    fu_pkg::tag_t [N_CDB-1:0]  sel_tag;
    fu_pkg::data_t [N_CDB-1:0] sel_data;
    fu_pkg::rob_t [N_CDB-1:0]  sel_rob;

    // next free CDB port
    int fill;

    always_comb begin
        alu_grant  = '0;
        mult_grant = 1'b0;
        sel_valid  = '0;
        sel_tag    = '0;
        sel_data   = '0;
        sel_rob    = '0;
        fill       = 0;

        // multiplier first, it stalls its whole pipe
        if (mult_done) begin
            mult_grant      = 1'b1;
            sel_valid[0]    = 1'b1;
            sel_tag[0]      = mult_done_tag;
            sel_data[0]     = mult_done_data;
            sel_rob[0]      = mult_done_rob;
            fill            = 1;
        end

        for (int j = 0; j < NUM_ALU; j++) begin
            if (alu_done[j] && fill < N_CDB) begin
                alu_grant[j]    = 1'b1;
                sel_valid[fill] = 1'b1;
                sel_tag[fill]   = alu_done_tag[j];
                sel_data[fill]  = alu_done_data[j];
                sel_rob[fill]   = alu_done_rob[j];
                fill            = fill + 1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            cdb_valid <= '0;
        end else begin
            cdb_valid <= sel_valid;
        end
    end

    always_ff @(posedge clock) begin
        cdb_tag  <= sel_tag;
        cdb_data <= sel_data;
        cdb_rob  <= sel_rob;
    end

endmodule

/* hw/fu_mult.sv */
`timescale 1ns/1ps

module fu_mult #(
    parameter int MULT_STAGES = fu_pkg::DEF_MULT_STAGES
) (
    input  logic           clock,
    input  logic           reset,
    input  logic           squash,
    input  logic           start,
    input  fu_pkg::fu_op_e op,
    input  fu_pkg::tag_t   tag,
    input  fu_pkg::rob_t   rob,
    input  fu_pkg::data_t  a,
    input  fu_pkg::data_t  b,
    input  logic           grant,

    output logic           ready,
    output logic           done,
    output fu_pkg::tag_t   done_tag,
    output fu_pkg::rob_t   done_rob,
    output fu_pkg::data_t  done_data
);

    localparam int LAST = MULT_STAGES - 1;

    logic signed [2*fu_pkg::DATA_W-1:0] product;

    logic [MULT_STAGES-1:0]       stage_valid;
    fu_pkg::fu_op_e               stage_op   [MULT_STAGES];
    fu_pkg::tag_t                 stage_tag  [MULT_STAGES];
    fu_pkg::rob_t                 stage_rob  [MULT_STAGES];
    logic [2*fu_pkg::DATA_W-1:0]  stage_prod [MULT_STAGES];

    logic advance;

    assign product = $signed(a) * $signed(b);

    // whole pipe moves unless the tail is stuck waiting for the CDB
    assign advance = ~stage_valid[LAST] | grant;

    // stage 0 may still fill a bubble while the rest is frozen
    assign ready = advance | ~stage_valid[0];

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            stage_valid <= '0;
        end else begin
            if (advance) begin
                for (int i = 1; i < MULT_STAGES; i++) begin
                    stage_valid[i] <= stage_valid[i-1];
                end
            end
            if (ready) begin
                stage_valid[0] <= start;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            for (int i = 1; i < MULT_STAGES; i++) begin
                stage_op[i]   <= stage_op[i-1];
                stage_tag[i]  <= stage_tag[i-1];
                stage_rob[i]  <= stage_rob[i-1];
                stage_prod[i] <= stage_prod[i-1];
            end
        end
        if (ready && start) begin
            stage_op[0]   <= op;
            stage_tag[0]  <= tag;
            stage_rob[0]  <= rob;
            stage_prod[0] <= product;
        end
    end

    assign done     = stage_valid[LAST];
    assign done_tag = stage_tag[LAST];
    assign done_rob = stage_rob[LAST];

    // half select at the tail
    assign done_data = (stage_op[LAST] == fu_pkg::OP_MULH) ?
                       stage_prod[LAST][2*fu_pkg::DATA_W-1:fu_pkg::DATA_W] :
                       stage_prod[LAST][fu_pkg::DATA_W-1:0];

endmodule

/* hw/fu_alu.sv */
`timescale 1ns/1ps

module fu_alu (
    input  logic           clock,
    input  logic           reset,
    input  logic           squash,
    input  logic           start,
    input  fu_pkg::fu_op_e op,
    input  fu_pkg::tag_t   tag,
    input  fu_pkg::rob_t   rob,
    input  fu_pkg::data_t  a,
    input  fu_pkg::data_t  b,
    input  logic           grant,

    output logic           free,
    output logic           done,
    output fu_pkg::tag_t   done_tag,
    output fu_pkg::rob_t   done_rob,
    output fu_pkg::data_t  done_data,
    output logic           cond_valid,
    output logic           cond_taken,
    output fu_pkg::rob_t   cond_rob
);

    fu_pkg::data_t result;
    logic          taken;
    logic          signed_lt;
    logic          is_branch;

    assign signed_lt = $signed(a) < $signed(b);
    assign is_branch = fu_pkg::is_branch_op(op);

    always_comb begin
        case (op)
            fu_pkg::OP_ADD: result = a + b;
            fu_pkg::OP_SUB: result = a - b;
            fu_pkg::OP_AND: result = a & b;
            fu_pkg::OP_OR:  result = a | b;
            fu_pkg::OP_XOR: result = a ^ b;
            fu_pkg::OP_SLT: result = {{(fu_pkg::DATA_W-1){1'b0}}, signed_lt};
            fu_pkg::OP_SLL: result = a << b[4:0];
            fu_pkg::OP_SRL: result = a >> b[4:0];
            default:        result = '0;
        endcase
    end

    always_comb begin
        case (op)
            fu_pkg::OP_BEQ: taken = (a == b);
            fu_pkg::OP_BNE: taken = (a != b);
            fu_pkg::OP_BLT: taken = signed_lt;
            default:        taken = 1'b0;
        endcase
    end

    // a granted result leaves this cycle, so a new op may land
    assign free = ~done | grant;

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            done       <= 1'b0;
            cond_valid <= 1'b0;
        end else begin
            cond_valid <= start & is_branch;
            if (start && !is_branch) begin
                done <= 1'b1;
            end else if (grant) begin
                done <= 1'b0;
            end
        end
    end

    // result hold register
    always_ff @(posedge clock) begin
        if (start && !is_branch) begin
            done_tag  <= tag;
            done_rob  <= rob;
            done_data <= result;
        end
        if (start) begin
            cond_taken <= taken;
            cond_rob   <= rob;
        end
    end

endmodule

/* hw/fu_issue_decode.sv */
`timescale 1ns/1ps

module fu_issue_decode #(
    parameter int ISSUE_W = fu_pkg::DEF_ISSUE_W,
    parameter int NUM_ALU = fu_pkg::DEF_NUM_ALU
) (
    input  logic [ISSUE_W-1:0]            issue_valid,
    input  fu_pkg::fu_op_e [ISSUE_W-1:0]  issue_op,
    input  fu_pkg::tag_t [ISSUE_W-1:0]    issue_tag,
    input  fu_pkg::rob_t [ISSUE_W-1:0]    issue_rob,
    input  fu_pkg::data_t [ISSUE_W-1:0]   issue_a,
    input  fu_pkg::data_t [ISSUE_W-1:0]   issue_b,
    input  logic [NUM_ALU-1:0]            alu_free,

    output logic [NUM_ALU-1:0]            alu_start,
    output fu_pkg::fu_op_e [NUM_ALU-1:0]  alu_op,
    output fu_pkg::tag_t [NUM_ALU-1:0]    alu_tag,
    output fu_pkg::rob_t [NUM_ALU-1:0]    alu_rob,
    output fu_pkg::data_t [NUM_ALU-1:0]   alu_a,
    output fu_pkg::data_t [NUM_ALU-1:0]   alu_b,

    output logic                          mult_start,
    output fu_pkg::fu_op_e                mult_op,
    output fu_pkg::tag_t                  mult_tag,
    output fu_pkg::rob_t                  mult_rob,
    output fu_pkg::data_t                 mult_a,
    output fu_pkg::data_t                 mult_b
);

    // ALUs not yet claimed by an earlier slot
    logic [NUM_ALU-1:0] unclaimed;
    logic               placed;

    always_comb begin
        alu_start  = '0;
        alu_tag    = '0;
        alu_rob    = '0;
        alu_a      = '0;
        alu_b      = '0;
        mult_start = 1'b0;
        mult_op    = fu_pkg::OP_MUL;
        mult_tag   = '0;
        mult_rob   = '0;
        mult_a     = '0;
        mult_b     = '0;
        for (int j = 0; j < NUM_ALU; j++) begin
            alu_op[j] = fu_pkg::OP_ADD;
        end

        unclaimed = alu_free;
        placed    = 1'b0;

        for (int i = 0; i < ISSUE_W; i++) begin
            placed = 1'b0;
            if (issue_valid[i] && fu_pkg::is_mult_op(issue_op[i])) begin
                // at most one multiply per cycle
                mult_start = 1'b1;
                mult_op    = issue_op[i];
                mult_tag   = issue_tag[i];
                mult_rob   = issue_rob[i];
                mult_a     = issue_a[i];
                mult_b     = issue_b[i];
            end else if (issue_valid[i]) begin
                // lowest free ALU wins
                for (int j = 0; j < NUM_ALU; j++) begin
                    if (!placed && unclaimed[j]) begin
                        alu_start[j] = 1'b1;
                        alu_op[j]    = issue_op[i];
                        alu_tag[j]   = issue_tag[i];
                        alu_rob[j]   = issue_rob[i];
                        alu_a[j]     = issue_a[i];
                        alu_b[j]     = issue_b[i];
                        unclaimed[j] = 1'b0;
                        placed       = 1'b1;
                    end
                end
            end
        end
    end

endmodule

/* hw/fu_pkg.sv */
package fu_pkg;

    // default sizing for the top level
    localparam int DEF_ISSUE_W     = 2;
    localparam int DEF_NUM_ALU     = 3;
    localparam int DEF_N_CDB       = 2;
    localparam int DEF_MULT_STAGES = 4;

    localparam int DATA_W = 32;
    localparam int TAG_W  = 6;
    localparam int ROB_W  = 5;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [ROB_W-1:0]  rob_t;

    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLT  = 4'd5,
        OP_SLL  = 4'd6,
        OP_SRL  = 4'd7,
        // compares, outcome goes to the ROB only
        OP_BEQ  = 4'd8,
        OP_BNE  = 4'd9,
        OP_BLT  = 4'd10,
        // multiplier class
        OP_MUL  = 4'd11,
        OP_MULH = 4'd12
    } fu_op_e;

    function automatic logic is_mult_op(fu_op_e op);
        return (op == OP_MUL) || (op == OP_MULH);
    endfunction

    function automatic logic is_branch_op(fu_op_e op);
        return (op == OP_BEQ) || (op == OP_BNE) || (op == OP_BLT);
    endfunction

endpackage
